// File: design/backing_ram.sv
`timescale 1ns/1ps

module backing_ram (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  cache_bus_pkg::be_req_t be_req_i,
   output cache_bus_pkg::be_rsp_t be_rsp_o
);

   cache_cfg_pkg::word_t mem [cache_cfg_pkg::RAM_DEPTH];
   cache_cfg_pkg::word_t rdata_q;
   logic                 rvalid_q;
   logic                 rd_req;

   // Zero strobes mark a read
   assign rd_req = be_req_i.avalid && !(|be_req_i.wstrb);

   always_ff @(posedge clk_i) begin
      if (be_req_i.avalid) begin
         for (int b = 0; b < cache_cfg_pkg::NBYTES; b++) begin
            if (be_req_i.wstrb[b]) begin
               mem[be_req_i.addr][8*b +: 8] <= be_req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_req) begin
         rdata_q <= mem[be_req_i.addr];
      end
   end

   // One-cycle read-valid pulse
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_req;
      end
   end

   always_comb begin
      be_rsp_o.rvalid = rvalid_q;
      be_rsp_o.rdata  = rdata_q;
   end

endmodule

// File: design/cache_bus_pkg.sv
package cache_bus_pkg;

   // Front-end native port, read when wstrb is zero
   typedef struct packed {
      logic                             avalid;
      logic [cache_cfg_pkg::ADDR_W-1:0] addr;
      cache_cfg_pkg::word_t             wdata;
      logic [cache_cfg_pkg::NBYTES-1:0] wstrb;
   } fe_req_t;

   typedef struct packed {
      logic                 ready;
      logic                 rvalid;
      cache_cfg_pkg::word_t rdata;
   } fe_rsp_t;

   // Back-end port toward the memory, always ready
   typedef struct packed {
      logic                             avalid;
      logic [cache_cfg_pkg::ADDR_W-1:0] addr;
      cache_cfg_pkg::word_t             wdata;
      logic [cache_cfg_pkg::NBYTES-1:0] wstrb;
   } be_req_t;

   typedef struct packed {
      logic                 rvalid;
      cache_cfg_pkg::word_t rdata;
   } be_rsp_t;

endpackage

// File: design/cache_cfg_pkg.sv
package cache_cfg_pkg;

   // Word geometry
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;

   // Word address split into tag, index and offset
   localparam int ADDR_W     = 10;
   localparam int OFFSET_W   = 2;
   localparam int LINE_WORDS = 1 << OFFSET_W;
   localparam int INDEX_W    = 4;
   localparam int NLINES     = 1 << INDEX_W;
   localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

   // Backing memory covers the whole word address space
   localparam int RAM_DEPTH = 1 << ADDR_W;

   typedef logic [DATA_W-1:0] word_t;

   // Overlay on a word address
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } addr_fields_t;

endpackage

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  cache_bus_pkg::fe_req_t             fe_req_i,
   output cache_bus_pkg::fe_rsp_t             fe_rsp_o,
   output logic                               lookup_en_o,
   output logic [cache_cfg_pkg::INDEX_W-1:0]  lookup_idx_o,
   output logic [cache_cfg_pkg::OFFSET_W-1:0] lookup_off_o,
   input  logic [cache_cfg_pkg::TAG_W-1:0]    tag_i,
   input  logic                               valid_i,
   output logic                               tag_fill_en_o,
   output logic [cache_cfg_pkg::TAG_W-1:0]    tag_fill_tag_o,
   input  cache_cfg_pkg::word_t               data_i,
   output logic                               data_wr_en_o,
   output logic [cache_cfg_pkg::INDEX_W-1:0]  data_wr_idx_o,
   output logic [cache_cfg_pkg::OFFSET_W-1:0] data_wr_off_o,
   output cache_cfg_pkg::word_t               data_wr_data_o,
   output logic [cache_cfg_pkg::NBYTES-1:0]   data_wr_strb_o,
   output cache_bus_pkg::be_req_t             be_req_o,
   input  cache_bus_pkg::be_rsp_t             be_rsp_i
);

   typedef enum logic {
      S_IDLE,
      S_REFILL
   } state_t;

   state_t                              state_q;
   cache_bus_pkg::fe_req_t              req_q;
   logic                                req_pending_q;
   cache_cfg_pkg::addr_fields_t         in_addr;
   cache_cfg_pkg::addr_fields_t         req_addr;
   logic                                ready;
   logic                                accept;
   logic                                req_read;
   logic                                hit;
   logic                                read_hit;
   logic                                read_miss;
   logic                                write_now;
   logic [cache_cfg_pkg::OFFSET_W:0]    issue_cnt_q;
   logic [cache_cfg_pkg::OFFSET_W-1:0]  ret_cnt_q;
   logic                                refill_ret;
   logic                                last_ret;
   cache_cfg_pkg::word_t                miss_word_q;
   logic                                miss_rvalid_q;

   assign in_addr  = cache_cfg_pkg::addr_fields_t'(fe_req_i.addr);
   assign req_addr = cache_cfg_pkg::addr_fields_t'(req_q.addr);

   // Hit or miss, one cycle after accept
   assign req_read  = ~|req_q.wstrb;
   assign hit       = valid_i && (tag_i == req_addr.tag);
   assign read_hit  = req_pending_q && req_read && hit;
   assign read_miss = req_pending_q && req_read && !hit;
   assign write_now = req_pending_q && !req_read;

   // Stall the front end as soon as a miss shows up
   assign ready  = (state_q == S_IDLE) && !read_miss;
   assign accept = fe_req_i.avalid && ready;

   assign lookup_en_o  = accept;
   assign lookup_idx_o = in_addr.index;
   assign lookup_off_o = in_addr.offset;

   assign refill_ret = (state_q == S_REFILL) && be_rsp_i.rvalid;
   assign last_ret   = refill_ret &&
                       (ret_cnt_q == cache_cfg_pkg::OFFSET_W'(cache_cfg_pkg::LINE_WORDS - 1));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         req_pending_q <= 1'b0;
      end else begin
         req_pending_q <= accept;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
   end

   // Refill sequencer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q       <= S_IDLE;
         issue_cnt_q   <= '0;
         ret_cnt_q     <= '0;
         miss_rvalid_q <= 1'b0;
      end else begin
         miss_rvalid_q <= last_ret;
         case (state_q)
            S_IDLE: begin
               if (read_miss) begin
                  state_q     <= S_REFILL;
                  issue_cnt_q <= '0;
                  ret_cnt_q   <= '0;
               end
            end
            S_REFILL: begin
               if (!issue_cnt_q[cache_cfg_pkg::OFFSET_W]) begin
                  issue_cnt_q <= issue_cnt_q + 1'b1;
               end
               if (refill_ret) begin
                  ret_cnt_q <= ret_cnt_q + 1'b1;
               end
               if (last_ret) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Requested word kept as it streams past
   always_ff @(posedge clk_i) begin
      if (refill_ret && (ret_cnt_q == req_addr.offset)) begin
         miss_word_q <= be_rsp_i.rdata;
      end
   end

   always_comb begin
      be_req_o = '0;
      if (state_q == S_REFILL) begin
         be_req_o.avalid = !issue_cnt_q[cache_cfg_pkg::OFFSET_W];
         be_req_o.addr   = {req_addr.tag, req_addr.index,
                            issue_cnt_q[cache_cfg_pkg::OFFSET_W-1:0]};
      end else if (write_now) begin
         // Write-through
         be_req_o.avalid = 1'b1;
         be_req_o.addr   = req_q.addr;
         be_req_o.wdata  = req_q.wdata;
         be_req_o.wstrb  = req_q.wstrb;
      end
   end

   always_comb begin
      data_wr_en_o   = 1'b0;
      data_wr_idx_o  = req_addr.index;
      data_wr_off_o  = req_addr.offset;
      data_wr_data_o = req_q.wdata;
      data_wr_strb_o = req_q.wstrb;
      if (refill_ret) begin
         data_wr_en_o   = 1'b1;
         data_wr_off_o  = ret_cnt_q;
         data_wr_data_o = be_rsp_i.rdata;
         data_wr_strb_o = '1;
      end else if (write_now && hit) begin
         data_wr_en_o = 1'b1;
      end
   end

   assign tag_fill_en_o  = last_ret;
   assign tag_fill_tag_o = req_addr.tag;

   always_comb begin
      fe_rsp_o.ready  = ready;
      fe_rsp_o.rvalid = read_hit || miss_rvalid_q;
      fe_rsp_o.rdata  = miss_rvalid_q ? miss_word_q : data_i;
   end

endmodule

// File: design/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
   input  logic                               clk_i,
   input  logic                               rd_en_i,
   input  logic [cache_cfg_pkg::INDEX_W-1:0]  rd_idx_i,
   input  logic [cache_cfg_pkg::OFFSET_W-1:0] rd_off_i,
   input  logic                               wr_en_i,
   input  logic [cache_cfg_pkg::INDEX_W-1:0]  wr_idx_i,
   input  logic [cache_cfg_pkg::OFFSET_W-1:0] wr_off_i,
   input  cache_cfg_pkg::word_t               wr_data_i,
   input  logic [cache_cfg_pkg::NBYTES-1:0]   wr_strb_i,
   output cache_cfg_pkg::word_t               rd_data_o
);

   cache_cfg_pkg::word_t mem [cache_cfg_pkg::NLINES][cache_cfg_pkg::LINE_WORDS];
   cache_cfg_pkg::word_t merged_word;
   logic                 wr_hits_rd;

   // Byte merge of the addressed word
   always_comb begin
      merged_word = mem[wr_idx_i][wr_off_i];
      for (int b = 0; b < cache_cfg_pkg::NBYTES; b++) begin
         if (wr_strb_i[b]) begin
            merged_word[8*b +: 8] = wr_data_i[8*b +: 8];
         end
      end
   end

   // Read of the word being written returns the new value
   assign wr_hits_rd = wr_en_i && (rd_idx_i == wr_idx_i) && (rd_off_i == wr_off_i);

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_idx_i][wr_off_i] <= merged_word;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         if (wr_hits_rd) begin
            rd_data_o <= merged_word;
         end else begin
            rd_data_o <= mem[rd_idx_i][rd_off_i];
         end
      end
   end

endmodule

// File: design/cache_sim_top.sv
`timescale 1ns/1ps

module cache_sim_top (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  cache_bus_pkg::fe_req_t fe_req_i,
   output cache_bus_pkg::fe_rsp_t fe_rsp_o,
   input  logic                   invalidate_i
);

   logic                               lookup_en;
   logic [cache_cfg_pkg::INDEX_W-1:0]  lookup_idx;
   logic [cache_cfg_pkg::OFFSET_W-1:0] lookup_off;
   logic [cache_cfg_pkg::TAG_W-1:0]    stored_tag;
   logic                               stored_valid;
   logic                               tag_fill_en;
   logic [cache_cfg_pkg::TAG_W-1:0]    tag_fill_tag;
   cache_cfg_pkg::word_t               stored_word;
   logic                               data_wr_en;
   logic [cache_cfg_pkg::INDEX_W-1:0]  data_wr_idx;
   logic [cache_cfg_pkg::OFFSET_W-1:0] data_wr_off;
   cache_cfg_pkg::word_t               data_wr_data;
   logic [cache_cfg_pkg::NBYTES-1:0]   data_wr_strb;
   cache_bus_pkg::be_req_t             be_req;
   cache_bus_pkg::be_rsp_t             be_rsp;

   // Tag fill shares the data write index, both point at the refilled line
   cache_tag_store u_tag_store (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .lookup_en_i (lookup_en),
      .lookup_idx_i(lookup_idx),
      .fill_en_i   (tag_fill_en),
      .fill_idx_i  (data_wr_idx),
      .fill_tag_i  (tag_fill_tag),
      .invalidate_i(invalidate_i),
      .tag_o       (stored_tag),
      .valid_o     (stored_valid)
   );

   cache_data_store u_data_store (
      .clk_i    (clk_i),
      .rd_en_i  (lookup_en),
      .rd_idx_i (lookup_idx),
      .rd_off_i (lookup_off),
      .wr_en_i  (data_wr_en),
      .wr_idx_i (data_wr_idx),
      .wr_off_i (data_wr_off),
      .wr_data_i(data_wr_data),
      .wr_strb_i(data_wr_strb),
      .rd_data_o(stored_word)
   );

   cache_ctrl u_ctrl (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .fe_req_i      (fe_req_i),
      .fe_rsp_o      (fe_rsp_o),
      .lookup_en_o   (lookup_en),
      .lookup_idx_o  (lookup_idx),
      .lookup_off_o  (lookup_off),
      .tag_i         (stored_tag),
      .valid_i       (stored_valid),
      .tag_fill_en_o (tag_fill_en),
      .tag_fill_tag_o(tag_fill_tag),
      .data_i        (stored_word),
      .data_wr_en_o  (data_wr_en),
      .data_wr_idx_o (data_wr_idx),
      .data_wr_off_o (data_wr_off),
      .data_wr_data_o(data_wr_data),
      .data_wr_strb_o(data_wr_strb),
      .be_req_o      (be_req),
      .be_rsp_i      (be_rsp)
   );

   backing_ram u_ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .be_req_i(be_req),
      .be_rsp_o(be_rsp)
   );

endmodule

// File: design/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              lookup_en_i,
   input  logic [cache_cfg_pkg::INDEX_W-1:0] lookup_idx_i,
   input  logic                              fill_en_i,
   input  logic [cache_cfg_pkg::INDEX_W-1:0] fill_idx_i,
   input  logic [cache_cfg_pkg::TAG_W-1:0]   fill_tag_i,
   input  logic                              invalidate_i,
   output logic [cache_cfg_pkg::TAG_W-1:0]   tag_o,
   output logic                              valid_o
);

   logic [cache_cfg_pkg::TAG_W-1:0]  tags [cache_cfg_pkg::NLINES];
   logic [cache_cfg_pkg::NLINES-1:0] valid;

   // Tag array
   always_ff @(posedge clk_i) begin
      if (fill_en_i) begin
         tags[fill_idx_i] <= fill_tag_i;
      end
   end

   // Invalidate wins over a fill in the same cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid <= '0;
      end else if (invalidate_i) begin
         valid <= '0;
      end else if (fill_en_i) begin
         valid[fill_idx_i] <= 1'b1;
      end
   end

   // Registered lookup, result seen one cycle after accept
   always_ff @(posedge clk_i) begin
      if (lookup_en_i) begin
         tag_o <= tags[lookup_idx_i];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_o <= 1'b0;
      end else if (lookup_en_i) begin
         valid_o <= valid[lookup_idx_i];
      end
   end

endmodule

// File: sim.f
design/cache_cfg_pkg.sv
design/cache_bus_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_ctrl.sv
design/backing_ram.sv
design/cache_sim_top.sv
tests/cache_tb.sv

// File: tests/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

   localparam int WAIT_LIMIT = 40;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   invalidate;
   cache_bus_pkg::fe_req_t fe_req;
   cache_bus_pkg::fe_rsp_t fe_rsp;

   // Reference memory and expected read data
   cache_cfg_pkg::word_t ref_mem [cache_cfg_pkg::RAM_DEPTH];
   cache_cfg_pkg::word_t exp_mem [4];
   cache_cfg_pkg::word_t exp_head;
   logic [1:0]           head;
   logic [1:0]           tail;
   int                   pend_cnt;
   logic                 rd_accept;
   logic                 wr_accept;
   logic                 pop;
   logic                 want_hit;
   logic                 want_miss;
   string                test_name;
   int                   errors;
   int                   timeouts;
   int                   seed;

   cache_sim_top uut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .fe_req_i    (fe_req),
      .fe_rsp_o    (fe_rsp),
      .invalidate_i(invalidate)
   );

   always #50 clk = ~clk;

   function automatic cache_cfg_pkg::word_t merge_bytes(input cache_cfg_pkg::word_t old_w,
                                                        input cache_cfg_pkg::word_t new_w,
                                                        input logic [3:0] strb);
      cache_cfg_pkg::word_t res;
      res = old_w;
      for (int b = 0; b < cache_cfg_pkg::NBYTES; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign rd_accept = fe_req.avalid && fe_rsp.ready && (fe_req.wstrb == '0);
   assign wr_accept = fe_req.avalid && fe_rsp.ready && (fe_req.wstrb != '0);
   assign pop       = fe_rsp.rvalid && (pend_cnt != 0);
   assign exp_head  = exp_mem[head];

   // Model updated and expected word queued at acceptance
   always @(posedge clk) begin
      if (!rst_n) begin
         head     <= '0;
         tail     <= '0;
         pend_cnt <= 0;
      end else begin
         if (pop) begin
            head <= head + 1'b1;
         end
         if (rd_accept) begin
            exp_mem[tail] <= ref_mem[fe_req.addr];
            tail          <= tail + 1'b1;
         end
         if (wr_accept) begin
            ref_mem[fe_req.addr] <= merge_bytes(ref_mem[fe_req.addr], fe_req.wdata, fe_req.wstrb);
         end
         pend_cnt <= pend_cnt + int'(rd_accept) - int'(pop);
      end
   end

   a_reset: assert property (@(posedge clk) !rst_n |=> (fe_rsp.ready && !fe_rsp.rvalid))
      else begin
         errors++;
         $display("[ERROR] reset: expected ready=1 rvalid=0, actual ready=%b rvalid=%b",
                  $sampled(fe_rsp.ready), $sampled(fe_rsp.rvalid));
      end

   a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
                             fe_rsp.rvalid |-> (fe_rsp.rdata === exp_head))
      else begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", test_name,
                  $sampled(exp_head), $sampled(fe_rsp.rdata));
      end

   a_pending: assert property (@(posedge clk) disable iff (!rst_n)
                               fe_rsp.rvalid |-> (pend_cnt != 0))
      else begin
         errors++;
         $display("[ERROR] %s: rvalid came while no read was pending", test_name);
      end

   a_hit: assert property (@(posedge clk) disable iff (!rst_n)
                           (rd_accept && want_hit) |=> fe_rsp.rvalid)
      else begin
         errors++;
         $display("[ERROR] %s: expected rvalid=1 one cycle after a hit, actual rvalid=%b",
                  test_name, $sampled(fe_rsp.rvalid));
      end

   a_miss: assert property (@(posedge clk) disable iff (!rst_n)
                            (rd_accept && want_miss) |=> (!fe_rsp.ready && !fe_rsp.rvalid))
      else begin
         errors++;
         $display("[ERROR] %s: expected ready=0 rvalid=0 after a miss, actual ready=%b rvalid=%b",
                  test_name, $sampled(fe_rsp.ready), $sampled(fe_rsp.rvalid));
      end

   // Starts and ends one step after a rising edge
   task automatic send_req(input logic [cache_cfg_pkg::ADDR_W-1:0] addr,
                           input cache_cfg_pkg::word_t wdata,
                           input logic [cache_cfg_pkg::NBYTES-1:0] wstrb);
      int waited;
      waited        = 0;
      fe_req.avalid = 1'b1;
      fe_req.addr   = addr;
      fe_req.wdata  = wdata;
      fe_req.wstrb  = wstrb;
      while (!fe_rsp.ready && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (fe_rsp.ready) begin
         @(posedge clk);
         #1;
      end else begin
         timeouts++;
         $display("Timeout in %s, the cache never raised ready", test_name);
      end
      fe_req.avalid = 1'b0;
   endtask

   task automatic read_word(input logic [cache_cfg_pkg::ADDR_W-1:0] addr,
                            input logic hit, input logic miss);
      want_hit  = hit;
      want_miss = miss;
      send_req(addr, '0, '0);
      want_hit  = 1'b0;
      want_miss = 1'b0;
   endtask

   task automatic drain_reads();
      int waited;
      waited = 0;
      while (pend_cnt != 0 && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (pend_cnt != 0) begin
         timeouts++;
         $display("Timeout in %s, a read never returned its data", test_name);
      end
   endtask

   task automatic pulse_invalidate();
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
   endtask

   initial begin
      logic [31:0] rnd;
      logic [9:0]  addr;
      logic [3:0]  strb;
      seed       = 32'h71bc_6ec9;
      errors     = 0;
      timeouts   = 0;
      rst_n      = 1'b0;
      invalidate = 1'b0;
      fe_req     = '0;
      want_hit   = 1'b0;
      want_miss  = 1'b0;
      test_name  = "reset";
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;

      // Line at index 3, tag 0
      test_name = "write_then_read";
      for (int i = 0; i < 4; i++) begin
         send_req(10'h00c + 10'(i), 32'h1357_0000 + 32'(i * 17), 4'hf);
      end
      read_word(10'h00d, 1'b0, 1'b1);
      read_word(10'h00c, 1'b1, 1'b0);
      read_word(10'h00e, 1'b1, 1'b0);
      read_word(10'h00f, 1'b1, 1'b0);
      drain_reads();

      test_name = "partial_writes";
      send_req(10'h00e, 32'haabb_ccdd, 4'b0101);
      read_word(10'h00e, 1'b1, 1'b0);
      send_req(10'h00e, 32'h5a00_0000, 4'b1000);
      read_word(10'h00e, 1'b1, 1'b0);
      drain_reads();
      pulse_invalidate();
      read_word(10'h00e, 1'b0, 1'b1);
      drain_reads();

      // Same index 5, tags 1 and 2
      test_name = "conflicts";
      send_req(10'h056, 32'h0bad_cafe, 4'hf);
      send_req(10'h096, 32'h600d_f00d, 4'hf);
      repeat (2) begin
         read_word(10'h056, 1'b0, 1'b1);
         read_word(10'h096, 1'b0, 1'b1);
      end
      drain_reads();
      send_req(10'h056, 32'h1234_5678, 4'hf);
      read_word(10'h056, 1'b0, 1'b1);
      drain_reads();

      test_name = "invalidate";
      read_word(10'h056, 1'b1, 1'b0);
      drain_reads();
      pulse_invalidate();
      read_word(10'h056, 1'b0, 1'b1);
      drain_reads();

      // 64 addresses over four tags and four indices
      test_name = "random_mix";
      for (int i = 0; i < 64; i++) begin
         addr = {2'b10, i[5:4], 2'b00, i[3:2], i[1:0]};
         send_req(addr, $random(seed), 4'hf);
      end
      for (int i = 0; i < 300; i++) begin
         rnd  = $random(seed);
         addr = {2'b10, rnd[5:4], 2'b00, rnd[3:2], rnd[1:0]};
         if (rnd[8]) begin
            read_word(addr, 1'b0, 1'b0);
         end else begin
            strb = rnd[12:9];
            if (strb == '0) begin
               strb = 4'hf;
            end
            send_req(addr, $random(seed), strb);
         end
      end
      drain_reads();
      repeat (2) @(posedge clk);

      $display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
